/* files.f */
hdl/game_pkg.sv
hdl/display_pkg.sv
hdl/tick_timer.sv
hdl/game_fsm.sv
hdl/fruit_lane.sv
hdl/player_slider.sv
hdl/score_keeper.sv
hdl/fruit_catch_top.sv
test/fruit_catch_checker.sv
test/fruit_catch_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module fruit_catch_tb -f files.f -o fruit_catch_sim

sim_out=$(./obj_dir/fruit_catch_sim) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1

/* test/fruit_catch_tb.sv */
`timescale 1ns/1ps

module fruit_catch_tb import game_pkg::*, display_pkg::*; ();

    localparam int GAME_CYCLES    = 20000;   // Bound on one game
    localparam int TIMEOUT_CYCLES = 200000;  // Eight bounded games plus the short tests

    logic        CLOCK_50;
    logic        KEY;
    logic        move_left;
    logic        move_right;
    fruit_t      fruit_a;
    fruit_t      fruit_b;
    x_coord_t    player_x;
    score_t      score;
    logic [1:0]  lives;
    logic        game_over;
    seg_t        hex_tens;
    seg_t        hex_units;
    seg_t        hex_lives;

    // Reference model state from the last sample
    fruit_t      last_a;
    fruit_t      last_b;
    x_coord_t    last_x;
    logic        last_over;
    int          exp_score;
    int          exp_lives;
    int          catches;                    // Since last reset
    int          misses;
    int          respawns_a;
    int          respawns_b;
    logic [3:0]  lives_shown;                // One bit per checked lives value
    logic [31:0] rng;
    int          errors;
    int          cycles = 0;

    fruit_catch_top #(
        .FALL_A_PERIOD(40),
        .FALL_B_PERIOD(30),
        .MOVE_PERIOD  (20)
    ) uut (
        .CLOCK_50  (CLOCK_50),
        .KEY       (KEY),
        .move_left (move_left),
        .move_right(move_right),
        .fruit_a   (fruit_a),
        .fruit_b   (fruit_b),
        .player_x  (player_x),
        .score     (score),
        .lives     (lives),
        .game_over (game_over),
        .hex_tens  (hex_tens),
        .hex_units (hex_units),
        .hex_lives (hex_lives)
    );

    always #50 CLOCK_50 = ~CLOCK_50;         // 100 ns period

    always @(posedge CLOCK_50) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, a test never completed", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Active low with bit 0 on top and bit 6 in the middle
    function automatic seg_t digit_segments(input int d);
        case (d)
            0: return 7'b1000000;
            1: return 7'b1111001;
            2: return 7'b0100100;
            3: return 7'b0110000;
            4: return 7'b0011001;
            5: return 7'b0010010;
            6: return 7'b0000010;
            7: return 7'b1111000;
            8: return 7'b0000000;
            9: return 7'b0011000;
            default: return 7'b1111111;
        endcase
    endfunction

    function automatic logic fruit_overlaps(input fruit_t f, input x_coord_t px);
        return (int'(f.x) + FRUIT_SIZE > int'(px)) && (int'(f.x) < int'(px) + BASKET_WIDTH);
    endfunction

    task automatic report_mismatch(input string name, input int expected, input int actual);
        errors++;
        $display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Per-cycle model and checks at each falling edge
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_lane(input string name, input fruit_t prev, input fruit_t now,
                              output logic respawned);
        logic catch_due;
        respawned = 1'b0;
        catch_due = (prev.y == CATCH_ROW) && fruit_overlaps(prev, last_x);
        if (now.y == prev.y) begin
            if (now.x != prev.x)
                report_mismatch({name, ".x"}, int'(prev.x), int'(now.x));
        end else if (catch_due || prev.y == Y_MAX) begin
            respawned = 1'b1;                // Back to the top
            if (now.y != 0)
                report_mismatch({name, ".y"}, 0, int'(now.y));
            if (now.x < SPAWN_MIN_X || now.x > SPAWN_MAX_X)
                report_failure({name, " respawned outside the spawn columns"});
            if (catch_due) begin
                catches++;
                exp_score = (exp_score < 99) ? exp_score + 1 : 99;
            end else begin
                misses++;
                exp_lives = (exp_lives > 0) ? exp_lives - 1 : 0;
            end
        end else begin
            if (int'(now.y) != int'(prev.y) + 1)
                report_mismatch({name, ".y"}, int'(prev.y) + 1, int'(now.y));
            if (now.x != prev.x)
                report_mismatch({name, ".x"}, int'(prev.x), int'(now.x));
        end
    endtask

    task automatic check_player(input x_coord_t prev, input x_coord_t now);
        int expected;
        if (now != prev) begin
            if (move_right && prev < PLAYER_MAX_X)
                expected = int'(prev) + 1;   // Right wins over left
            else if (move_left && prev > 0)
                expected = int'(prev) - 1;
            else
                expected = int'(prev);
            if (int'(now) != expected)
                report_mismatch("player_x", expected, int'(now));
        end
    endtask

    task automatic check_digits();
        seg_t tens_exp;
        tens_exp = (exp_score < 10) ? 7'b1111111 : digit_segments(exp_score / 10);
        if (hex_tens != tens_exp)
            report_mismatch("hex_tens", int'(tens_exp), int'(hex_tens));
        if (hex_units != digit_segments(exp_score % 10))
            report_mismatch("hex_units", int'(digit_segments(exp_score % 10)), int'(hex_units));
        if (hex_lives != digit_segments(exp_lives))
            report_mismatch("hex_lives", int'(digit_segments(exp_lives)), int'(hex_lives));
    endtask

    task automatic observe_cycle();
        logic resp_a;
        logic resp_b;
        // Score and lives trail the respawn by one cycle
        if (int'(score) != exp_score)
            report_mismatch("score", exp_score, int'(score));
        if (int'(lives) != exp_lives)
            report_mismatch("lives", exp_lives, int'(lives));
        check_digits();
        lives_shown[exp_lives] = 1'b1;
        if (game_over && exp_lives != 0)
            report_failure("game_over is high while lives remain");
        if (last_over && !game_over)
            report_failure("game_over fell without a reset");
        if (last_over && (fruit_a != last_a || fruit_b != last_b || player_x != last_x))
            report_failure("a position changed after game over");
        check_lane("fruit_a", last_a, fruit_a, resp_a);
        check_lane("fruit_b", last_b, fruit_b, resp_b);
        check_player(last_x, player_x);
        if (resp_a)
            respawns_a++;
        if (resp_b)
            respawns_b++;
        last_a    = fruit_a;
        last_b    = fruit_b;
        last_x    = player_x;
        last_over = game_over;
    endtask

    task automatic next_cycle();
        @(negedge CLOCK_50);
        observe_cycle();
    endtask

    task automatic apply_reset();
        @(negedge CLOCK_50);
        KEY        = 1'b0;
        move_left  = 1'b0;
        move_right = 1'b0;
        repeat (5) @(negedge CLOCK_50);
        KEY        = 1'b1;
        exp_score  = 0;
        exp_lives  = int'(START_LIVES);
        catches    = 0;
        misses     = 0;
        respawns_a = 0;
        respawns_b = 0;
        last_a     = fruit_a;                // Spawn column comes from the lane seed
        last_b     = fruit_b;
        last_x     = player_x;
        last_over  = game_over;
    endtask

    // Random buttons, or half the time steer toward the lowest live fruit
    task automatic pick_buttons(input logic allow_chase);
        fruit_t target;
        rng = lcg_next(rng);
        if (allow_chase && rng[31]) begin
            if (fruit_a.y <= CATCH_ROW && (fruit_a.y >= fruit_b.y || fruit_b.y > CATCH_ROW))
                target = fruit_a;
            else
                target = fruit_b;
            move_right = (int'(player_x) + 4 < int'(target.x)); // Centre basket on fruit
            move_left  = (int'(player_x) + 4 > int'(target.x));
        end else begin
            move_left  = rng[29];
            move_right = rng[28];
        end
    endtask

    task automatic play_game(input logic allow_chase, input logic stop_on_both,
                             output logic ended);
        int n;
        n = 0;
        while (!game_over && n < GAME_CYCLES && !(stop_on_both && catches > 0 && misses > 0)) begin
            if (n % 16 == 0)
                pick_buttons(allow_chase);
            next_cycle();
            n++;
        end
        ended = game_over;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////
    task automatic test_reset_state();
        apply_reset();
        if (score != 0)
            report_mismatch("score", 0, int'(score));
        if (lives != 2'd3)
            report_mismatch("lives", 3, int'(lives));
        if (game_over)
            report_mismatch("game_over", 0, 1);
        if (player_x != 8'd72)
            report_mismatch("player_x", 72, int'(player_x));
        if (fruit_a.y != 0)
            report_mismatch("fruit_a.y", 0, int'(fruit_a.y));
        if (fruit_b.y != 0)
            report_mismatch("fruit_b.y", 0, int'(fruit_b.y));
        if (fruit_a.x < SPAWN_MIN_X || fruit_a.x > SPAWN_MAX_X)
            report_failure("fruit_a starts outside the spawn columns");
        if (fruit_b.x < SPAWN_MIN_X || fruit_b.x > SPAWN_MAX_X)
            report_failure("fruit_b starts outside the spawn columns");
        if (hex_units != digit_segments(0))
            report_mismatch("hex_units", int'(digit_segments(0)), int'(hex_units));
        if (hex_tens != 7'b1111111)
            report_mismatch("hex_tens", 127, int'(hex_tens));
        if (hex_lives != digit_segments(3))
            report_mismatch("hex_lives", int'(digit_segments(3)), int'(hex_lives));
    endtask

    task automatic test_basket_movement();
        int       n;
        x_coord_t held;
        apply_reset();
        move_right = 1'b1;
        n = 0;
        while (player_x != PLAYER_MAX_X && n < 2000) begin
            next_cycle();
            n++;
        end
        repeat (64) next_cycle();            // Several move ticks against the edge
        if (player_x != PLAYER_MAX_X)
            report_mismatch("player_x", int'(PLAYER_MAX_X), int'(player_x));

        apply_reset();
        move_left = 1'b1;
        n = 0;
        while (player_x != 0 && n < 2000) begin
            next_cycle();
            n++;
        end
        repeat (64) next_cycle();
        if (player_x != 0)
            report_mismatch("player_x", 0, int'(player_x));

        // Both held away from either edge
        apply_reset();
        move_left  = 1'b1;
        move_right = 1'b1;
        n = 0;
        while (player_x == 8'd72 && n < 200) begin
            next_cycle();
            n++;
        end
        if (player_x != 8'd73)
            report_mismatch("player_x", 73, int'(player_x));

        move_left  = 1'b0;
        move_right = 1'b0;
        held = player_x;
        repeat (64) next_cycle();
        if (player_x != held)
            report_mismatch("player_x", int'(held), int'(player_x));
    endtask

    task automatic test_fall_steps();
        int n;
        apply_reset();
        n = 0;
        while ((respawns_a == 0 || respawns_b == 0) && n < 4000) begin
            if (n % 16 == 0)
                pick_buttons(1'b0);
            next_cycle();
            n++;
        end
        if (respawns_a == 0)
            report_failure("fruit_a never reached a respawn");
        if (respawns_b == 0)
            report_failure("fruit_b never reached a respawn");
    endtask

    task automatic test_catch_and_miss();
        int   game;
        logic ended;
        logic seen_catch;
        logic seen_miss;
        seen_catch = 1'b0;
        seen_miss  = 1'b0;
        game = 0;
        while (game < 6 && !(seen_catch && seen_miss)) begin
            apply_reset();
            play_game(1'b1, 1'b1, ended);
            seen_catch = seen_catch || (catches > 0);
            seen_miss  = seen_miss || (misses > 0);
            game++;
        end
        if (!seen_catch)
            report_failure("no fruit was caught in any game");
        if (!seen_miss)
            report_failure("no fruit was missed in any game");
    endtask

    task automatic test_digit_encoding();
        logic ended;
        apply_reset();
        lives_shown = 4'b0000;
        play_game(1'b0, 1'b0, ended);
        if (!ended)
            report_failure("game did not end while stepping the lives display");
        if (lives_shown != 4'b1111)
            report_failure("lives display did not pass through every value");
    endtask

    task automatic test_game_over();
        logic     ended;
        fruit_t   frozen_a;
        fruit_t   frozen_b;
        x_coord_t frozen_x;
        score_t   frozen_score;
        apply_reset();
        play_game(1'b0, 1'b0, ended);
        if (!ended)
            report_failure("game_over never rose after the third miss");
        frozen_a     = fruit_a;
        frozen_b     = fruit_b;
        frozen_x     = player_x;
        frozen_score = score;
        repeat (500) begin
            rng = lcg_next(rng);
            move_left  = rng[30];            // Buttons must have no effect now
            move_right = rng[29];
            next_cycle();
        end
        if (!game_over)
            report_mismatch("game_over", 1, 0);
        if (fruit_a != frozen_a)
            report_mismatch("fruit_a", int'(frozen_a), int'(fruit_a));
        if (fruit_b != frozen_b)
            report_mismatch("fruit_b", int'(frozen_b), int'(fruit_b));
        if (player_x != frozen_x)
            report_mismatch("player_x", int'(frozen_x), int'(player_x));
        if (score != frozen_score)
            report_mismatch("score", int'(frozen_score), int'(score));
    endtask

    initial begin
        CLOCK_50    = 1'b0;
        KEY         = 1'b0;
        move_left   = 1'b0;
        move_right  = 1'b0;
        rng         = 32'h1594;
        errors      = 0;
        lives_shown = 4'b0000;

        test_reset_state();
        test_basket_movement();
        test_fall_steps();
        test_catch_and_miss();
        test_digit_encoding();
        test_game_over();

        $display("Summary: %0d errors over %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* test/fruit_catch_checker.sv */
`timescale 1ns/1ps

module fruit_catch_checker import game_pkg::*; (
    input logic        CLOCK_50,
    input logic        KEY,
    input tick_t       pending,
    input tick_t       grant,
    input game_state_t state,
    input x_coord_t    player_x,
    input logic [1:0]  lives
);

    ////////////////////////////////////////////////////////////////////////////
    // Request/grant handshake
    ////////////////////////////////////////////////////////////////////////////
    a_grant_onehot: assert property (@(posedge CLOCK_50) disable iff (!KEY)
        $onehot0(3'(grant)))
        else $error("grant has more than one channel set: %b", 3'(grant));

    a_grant_pending: assert property (@(posedge CLOCK_50) disable iff (!KEY)
        (3'(grant) & ~3'(pending)) == 3'b000) // Only held ticks are served
        else $error("grant %b without pending %b", 3'(grant), 3'(pending));

    a_over_quiet: assert property (@(posedge CLOCK_50) disable iff (!KEY)
        (state == GAME_OVER) |-> (3'(grant) == 3'b000))
        else $error("grant %b while in GAME_OVER", 3'(grant));

    ////////////////////////////////////////////////////////////////////////////
    // Game data
    ////////////////////////////////////////////////////////////////////////////
    a_player_range: assert property (@(posedge CLOCK_50) disable iff (!KEY)
        player_x <= PLAYER_MAX_X)
        else $error("player_x %0d beyond right edge", player_x);

    // Lives only ever go down between resets
    a_lives_fall: assert property (@(posedge CLOCK_50) disable iff (!KEY)
        lives <= $past(lives))
        else $error("lives rose from %0d to %0d", $past(lives), lives);

endmodule

bind fruit_catch_top fruit_catch_checker u_checker (
    .CLOCK_50(CLOCK_50),
    .KEY     (KEY),
    .pending (pending),
    .grant   (grant),
    .state   (state),
    .player_x(player_x),
    .lives   (lives)
);

/* hdl/fruit_catch_top.sv */
`timescale 1ns/1ps

module fruit_catch_top import game_pkg::*, display_pkg::*; #(
    parameter int FALL_A_PERIOD = game_pkg::FALL_A_PERIOD,
    parameter int FALL_B_PERIOD = game_pkg::FALL_B_PERIOD,
    parameter int MOVE_PERIOD   = game_pkg::MOVE_PERIOD
) (
    input  logic       CLOCK_50,
    input  logic       KEY,                  // Async reset, active low
    input  logic       move_left,
    input  logic       move_right,
    output fruit_t     fruit_a,
    output fruit_t     fruit_b,
    output x_coord_t   player_x,
    output score_t     score,
    output logic [1:0] lives,
    output logic       game_over,
    output seg_t       hex_tens,
    output seg_t       hex_units,
    output seg_t       hex_lives
);

    tick_t       pending;
    tick_t       grant;
    game_state_t state;
    lane_event_t event_a;
    lane_event_t event_b;
    logic        out_of_lives;

    ////////////////////////////////////////////////////////////////////////////
    // Timing and sequencing
    ////////////////////////////////////////////////////////////////////////////
    tick_timer #(
        .FALL_A_PERIOD(FALL_A_PERIOD),
        .FALL_B_PERIOD(FALL_B_PERIOD),
        .MOVE_PERIOD  (MOVE_PERIOD)
    ) u_timer (
        .CLOCK_50(CLOCK_50),
        .KEY     (KEY),
        .grant   (grant),
        .pending (pending)
    );

    game_fsm u_fsm (
        .CLOCK_50    (CLOCK_50),
        .KEY         (KEY),
        .pending     (pending),
        .out_of_lives(out_of_lives),
        .grant       (grant),
        .state       (state)
    );

    assign game_over = (state == GAME_OVER);

    ////////////////////////////////////////////////////////////////////////////
    // Game objects and scoring
    ////////////////////////////////////////////////////////////////////////////
    fruit_lane #(.SPAWN_SEED(16'hACE1)) lane_a (
        .CLOCK_50   (CLOCK_50),
        .KEY        (KEY),
        .step       (grant.fall_a),
        .player_x   (player_x),
        .fruit      (fruit_a),
        .fruit_event(event_a)
    );

    fruit_lane #(.SPAWN_SEED(16'h5A3C)) lane_b ( // Different spawn sequence
        .CLOCK_50   (CLOCK_50),
        .KEY        (KEY),
        .step       (grant.fall_b),
        .player_x   (player_x),
        .fruit      (fruit_b),
        .fruit_event(event_b)
    );

    player_slider u_player (
        .CLOCK_50  (CLOCK_50),
        .KEY       (KEY),
        .step      (grant.move),
        .move_left (move_left),
        .move_right(move_right),
        .player_x  (player_x)
    );

    score_keeper u_score (
        .CLOCK_50    (CLOCK_50),
        .KEY         (KEY),
        .event_a     (event_a),
        .event_b     (event_b),
        .score       (score),
        .lives       (lives),
        .out_of_lives(out_of_lives),
        .hex_tens    (hex_tens),
        .hex_units   (hex_units),
        .hex_lives   (hex_lives)
    );

endmodule

/* hdl/score_keeper.sv */
`timescale 1ns/1ps

module score_keeper import game_pkg::*, display_pkg::*; (
    input  logic        CLOCK_50,
    input  logic        KEY,
    input  lane_event_t event_a,
    input  lane_event_t event_b,
    output score_t      score,
    output logic [1:0]  lives,
    output logic        out_of_lives,
    output seg_t        hex_tens,
    output seg_t        hex_units,
    output seg_t        hex_lives
);

    logic [1:0] n_caught;                    // Both lanes may report together
    logic [1:0] n_missed;
    logic [7:0] score_sum;
    logic [3:0] tens;
    logic [3:0] units;

    assign n_caught  = 2'(event_a.caught) + 2'(event_b.caught);
    assign n_missed  = 2'(event_a.missed) + 2'(event_b.missed);
    assign score_sum = {1'b0, score} + 8'(n_caught);

    always_ff @(posedge CLOCK_50 or negedge KEY) begin
        if (!KEY) begin
            score <= '0;
            lives <= START_LIVES;
        end else begin
            // Saturate at two digits
            score <= (score_sum > 8'(SCORE_MAX)) ? SCORE_MAX : score_sum[6:0];
            lives <= (lives > n_missed) ? lives - n_missed : 2'd0; // Floor at zero
        end
    end

    assign out_of_lives = (lives == 2'd0);

    ////////////////////////////////////////////////////////////////////////////
    // Seven segment digits
    ////////////////////////////////////////////////////////////////////////////
    assign tens  = 4'(score / 7'd10);
    assign units = 4'(score % 7'd10);

    assign hex_tens  = (tens == 4'd0) ? SEG_BLANK : SEG_DIGIT[tens]; // No leading zero
    assign hex_units = SEG_DIGIT[units];
    assign hex_lives = SEG_DIGIT[lives];

endmodule

/* hdl/player_slider.sv */
`timescale 1ns/1ps

module player_slider import game_pkg::*; (
    input  logic     CLOCK_50,
    input  logic     KEY,
    input  logic     step,
    input  logic     move_left,
    input  logic     move_right,
    output x_coord_t player_x
);

    logic can_right;
    logic can_left;

    assign can_right = move_right && (player_x < PLAYER_MAX_X); // Right edge clamp
    assign can_left  = move_left && (player_x != '0);

    // Right has priority when both buttons are held
    always_ff @(posedge CLOCK_50 or negedge KEY) begin
        if (!KEY) begin
            player_x <= PLAYER_START_X;
        end else if (step) begin
            if (can_right) begin
                player_x <= player_x + 1'b1;
            end else if (can_left) begin
                player_x <= player_x - 1'b1;
            end
        end
    end

endmodule

/* hdl/fruit_lane.sv */
`timescale 1ns/1ps

module fruit_lane import game_pkg::*; #(
    parameter logic [15:0] SPAWN_SEED = 16'hACE1  // Nonzero, distinct per lane
) (
    input  logic        CLOCK_50,
    input  logic        KEY,
    input  logic        step,
    input  x_coord_t    player_x,
    output fruit_t      fruit,
    output lane_event_t fruit_event
);

    localparam x_coord_t SPAN = x_coord_t'(SPAWN_MAX_X - SPAWN_MIN_X + 1'b1); // 134 columns

    logic [15:0] lfsr;
    x_coord_t    spawn_x;
    logic        overlap;
    logic        at_catch;
    logic        at_bottom;

    // Fold a raw byte onto the spawn range
    function automatic x_coord_t map_spawn(input logic [7:0] raw);
        logic [7:0] off;
        off = (raw >= SPAN) ? raw - SPAN : raw;
        return SPAWN_MIN_X + off;
    endfunction

    assign spawn_x = map_spawn(lfsr[7:0]);

    // Horizontal overlap of fruit and basket, 9 bits to avoid wrap
    assign overlap = (({1'b0, fruit.x} + 9'(FRUIT_SIZE)) > {1'b0, player_x})
                  && ({1'b0, fruit.x} < ({1'b0, player_x} + 9'(BASKET_WIDTH)));

    assign at_catch  = (fruit.y == CATCH_ROW) && overlap;
    assign at_bottom = (fruit.y == Y_MAX);

    always_ff @(posedge CLOCK_50 or negedge KEY) begin
        if (!KEY) begin
            lfsr        <= SPAWN_SEED;
            fruit.x     <= map_spawn(SPAWN_SEED[7:0]);
            fruit.y     <= '0;
            fruit_event <= '0;
        end else begin
            // Galois LFSR, taps 16,14,13,11
            lfsr        <= {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);
            fruit_event <= '0;                 // Single cycle pulse
            if (step) begin
                if (at_catch) begin
                    fruit_event.caught <= 1'b1;
                    fruit.x            <= spawn_x;
                    fruit.y            <= '0;
                end else if (at_bottom) begin
                    fruit_event.missed <= 1'b1; // Fell past the basket
                    fruit.x            <= spawn_x;
                    fruit.y            <= '0;
                end else begin
                    fruit.y <= fruit.y + 1'b1;
                end
            end
        end
    end

endmodule

/* hdl/game_fsm.sv */
`timescale 1ns/1ps

module game_fsm import game_pkg::*; (
    input  logic        CLOCK_50,
    input  logic        KEY,
    input  tick_t       pending,
    input  logic        out_of_lives,
    output tick_t       grant,
    output game_state_t state
);

    game_state_t state_next;

    always_ff @(posedge CLOCK_50 or negedge KEY) begin
        if (!KEY) begin
            state <= SERVE_FRUIT_A;
        end else begin
            state <= state_next;
        end
    end

    // Round robin A, B, player; grant only what is pending
    always_comb begin
        grant      = '0;
        state_next = state;
        case (state)
            SERVE_FRUIT_A: begin
                grant.fall_a = pending.fall_a;
                state_next   = SERVE_FRUIT_B;
            end
            SERVE_FRUIT_B: begin
                grant.fall_b = pending.fall_b;
                state_next   = SERVE_PLAYER;
            end
            SERVE_PLAYER: begin
                grant.move = pending.move;
                state_next = SERVE_FRUIT_A;
            end
            GAME_OVER: begin
                state_next = GAME_OVER;      // Only reset leaves
            end
            default: begin
                state_next = SERVE_FRUIT_A;
            end
        endcase

        // Last life gone, stop serving this very cycle
        if (out_of_lives) begin
            grant      = '0;
            state_next = GAME_OVER;
        end
    end

endmodule

/* hdl/tick_timer.sv */
`timescale 1ns/1ps

module tick_timer import game_pkg::*; #(
    parameter int FALL_A_PERIOD = game_pkg::FALL_A_PERIOD,
    parameter int FALL_B_PERIOD = game_pkg::FALL_B_PERIOD,
    parameter int MOVE_PERIOD   = game_pkg::MOVE_PERIOD
) (
    input  logic  CLOCK_50,
    input  logic  KEY,
    input  tick_t grant,
    output tick_t pending
);

    localparam int CNT_W = 20;               // Wide enough for 790000

    localparam logic [CNT_W-1:0] STEP  = CNT_W'(SPEEDUP_STEP);
    localparam logic [CNT_W-1:0] FLOOR = CNT_W'(MIN_PERIOD);

    logic [2:0] grant_vec;                   // {fall_a, fall_b, move}
    logic [2:0] pend_vec;

    assign grant_vec = grant;
    assign pending   = pend_vec;

    ////////////////////////////////////////////////////////////////////////////
    // One accelerating down-counter per channel
    ////////////////////////////////////////////////////////////////////////////
    for (genvar i = 0; i < 3; i++) begin : g_chan
        localparam int START = (i == 2) ? FALL_A_PERIOD :
                               ((i == 1) ? FALL_B_PERIOD : MOVE_PERIOD);

        logic [CNT_W-1:0] period;            // Current reload period
        logic [CNT_W-1:0] period_next;
        logic [CNT_W-1:0] count;
        logic             expire;
        logic             pend;

        assign expire = (count == '0);

        // Shrink by one step, never below the floor
        assign period_next = (period >= FLOOR + STEP) ? period - STEP : FLOOR;

        always_ff @(posedge CLOCK_50 or negedge KEY) begin
            if (!KEY) begin
                period <= CNT_W'(START);
                count  <= CNT_W'(START - 1);
                pend   <= 1'b0;
            end else begin
                if (expire) begin
                    period <= period_next;
                    count  <= period_next - 1'b1; // Next interval already faster
                end else begin
                    count <= count - 1'b1;
                end
                // Grant consumes the held tick, a fresh expiry sets it again
                pend <= expire | (pend & ~grant_vec[i]);
            end
        end

        assign pend_vec[i] = pend;
    end

endmodule

/* hdl/display_pkg.sv */
package display_pkg;

    // Active low segments, bit 0 top, bit 6 middle
    typedef logic [6:0] seg_t;
    typedef logic [6:0] score_t;

    localparam score_t SCORE_MAX = 7'd99;    // Two digits only

    localparam seg_t SEG_BLANK = 7'b1111111;

    //     0
    //   5   1
    //     6
    //   4   2
    //     3
    localparam seg_t SEG_DIGIT [10] = '{
        7'b1000000,                          // 0
        7'b1111001,                          // 1
        7'b0100100,                          // 2
        7'b0110000,                          // 3
        7'b0011001,                          // 4
        7'b0010010,                          // 5
        7'b0000010,                          // 6
        7'b1111000,                          // 7
        7'b0000000,                          // 8
        7'b0011000                           // 9
    };

endpackage

/* hdl/game_pkg.sv */
package game_pkg;

    // Playfield coordinates
    typedef logic [7:0] x_coord_t;           // Column, 0..159
    typedef logic [6:0] y_coord_t;           // Row, 0..119

    localparam x_coord_t X_MAX = 8'd159;
    localparam y_coord_t Y_MAX = 7'd119;

    localparam int FRUIT_SIZE   = 8;         // Fruit edge in pixels
    localparam int BASKET_WIDTH = 16;

    localparam y_coord_t BASKET_ROW = 7'd80;
    localparam y_coord_t CATCH_ROW  = y_coord_t'(BASKET_ROW - FRUIT_SIZE); // Fruit bottom meets basket

    localparam x_coord_t PLAYER_START_X = 8'd72;
    localparam x_coord_t PLAYER_MAX_X   = x_coord_t'(X_MAX + 1 - BASKET_WIDTH); // 144
    localparam x_coord_t SPAWN_MIN_X    = 8'd10;
    localparam x_coord_t SPAWN_MAX_X    = x_coord_t'(X_MAX - BASKET_WIDTH);     // 143

    // Tick periods in clock cycles
    localparam int FALL_A_PERIOD = 790000;
    localparam int FALL_B_PERIOD = 690000;
    localparam int MOVE_PERIOD   = 490000;
    localparam int SPEEDUP_STEP  = 5;        // Shrink per expiry
    localparam int MIN_PERIOD    = 8;        // Speed ceiling

    localparam logic [1:0] START_LIVES = 2'd3;

    // One bit per tick channel, fall_a is the MSB
    typedef struct packed {
        logic fall_a;
        logic fall_b;
        logic move;
    } tick_t;

    typedef struct packed {
        x_coord_t x;
        y_coord_t y;
    } fruit_t;

    typedef struct packed {
        logic caught;
        logic missed;
    } lane_event_t;

    typedef enum logic [1:0] {
        SERVE_FRUIT_A,
        SERVE_FRUIT_B,
        SERVE_PLAYER,
        GAME_OVER
    } game_state_t;

endpackage
